/* hdl/rv32_types.sv */
//####################################################################
// Shared types for the RV32IM execute stage and its GRNG extension
// Struct field order is the bit layout seen by the pipeline buffers
//####################################################################
`default_nettype none

package rv32_types;

    localparam int XLEN = 32;

    // Sequential pc step, also the link value offset for JAL/JALR
    localparam logic [XLEN-1:0] RV_PC_STEP = 32'd4;

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] RV_NOP = 32'h0000_0013;

    // GRNG LFSR constants, taps 64, 63, 61 and 60 in right-shift form
    localparam logic [63:0] GRNG_TAPS = 64'hD800_0000_0000_0000;
    localparam logic [63:0] GRNG_RESET_STATE = 64'h9E37_79B9_7F4A_7C15;
    // Mean of sixteen uniform nibbles
    localparam logic [9:0] GRNG_OFFSET = 10'd120;

    typedef logic [XLEN-1:0] rv32_word;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J
    } instr_type_t;

    typedef enum logic [1:0] {
        BYPASS_NONE,
        BYPASS_EXEC_BUFF,
        BYPASS_MEM_BUFF
    } bypass_sel_t;

    typedef enum logic [2:0] {
        ALU_IN_ZERO,
        ALU_IN_REG_1,
        ALU_IN_REG_2,
        ALU_IN_PC,
        ALU_IN_IMM
    } alu_in_sel_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS2
    } int_alu_op_t;

    // BR_ALWAYS serves JAL and JALR
    typedef enum logic [2:0] {
        BR_NONE,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        BR_ALWAYS
    } branch_op_t;

    typedef enum logic [1:0] {
        MUL,
        MULH,
        MULHSU,
        MULHU
    } mul_op_t;

    typedef enum logic [2:0] {
        WB_NONE,
        WB_PC4,
        WB_INT_ALU,
        WB_STORE,
        WB_MUL_UNIT,
        WB_GRNG
    } wb_src_t;

    // Index 0 is rs1, index 1 is rs2
    typedef struct packed {
        instr_type_t t;
        bypass_sel_t [2:0] bypass_rs;
        alu_in_sel_t [1:0] int_alu_input;
        int_alu_op_t int_alu_op;
        branch_op_t branch_op;
        mul_op_t mul_op;
        wb_src_t wb_result_src;
        logic grng_enable;
        logic grng_seed;
        logic reg_write;
    } decoded_instr_t;

    typedef struct packed {
        rv32_word instr;
        rv32_word pc;
        rv32_word [2:0] reg_data;
        decoded_instr_t decoded_instr;
    } decode_exec_buffer_t;

    typedef struct packed {
        rv32_word instr;
        rv32_word pc;
        decoded_instr_t decoded_instr;
        rv32_word mem_addr;
        rv32_word wb_result;
    } exec_mem_buffer_t;

    // Control word of an empty slot
    function automatic decoded_instr_t create_nop_ctrl();
        decoded_instr_t ctrl;
        ctrl.t = FMT_I;
        ctrl.bypass_rs = {BYPASS_NONE, BYPASS_NONE, BYPASS_NONE};
        ctrl.int_alu_input = {ALU_IN_ZERO, ALU_IN_ZERO};
        ctrl.int_alu_op = ALU_ADD;
        ctrl.branch_op = BR_NONE;
        ctrl.mul_op = MUL;
        ctrl.wb_result_src = WB_NONE;
        ctrl.grng_enable = 1'b0;
        ctrl.grng_seed = 1'b0;
        ctrl.reg_write = 1'b0;
        return ctrl;
    endfunction

endpackage

`default_nettype wire

/* hdl/rv32_immediate_gen.sv */
//####################################################################
// Immediate builder for the base RV32 formats, R format yields zero
//####################################################################
`default_nettype none

module rv32_immediate_gen (
    input  rv32_types::instr_type_t instr_type,
    input  rv32_types::rv32_word    instruction,
    output rv32_types::rv32_word    immediate
);
    import rv32_types::*;

    logic sign;

    assign sign = instruction[31];

    always_comb begin
        case (instr_type)
            FMT_I: begin
                immediate = {{20{sign}}, instruction[31:20]};
            end
            FMT_S: begin
                immediate = {{20{sign}}, instruction[31:25], instruction[11:7]};
            end
            // Branch offsets are even, bit 0 is implied
            FMT_B: begin
                immediate = {{19{sign}}, sign, instruction[7], instruction[30:25],
                             instruction[11:8], 1'b0};
            end
            FMT_U: begin
                immediate = {instruction[31:12], 12'b0};
            end
            FMT_J: begin
                immediate = {{11{sign}}, sign, instruction[19:12], instruction[20],
                             instruction[30:21], 1'b0};
            end
            default: begin
                immediate = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/rv32_int_alu.sv */
//####################################################################
// RV32I integer ALU, purely combinational
// Shift amount is op2[4:0], upper bits of op2 are ignored for shifts
//####################################################################
`default_nettype none

module rv32_int_alu (
    input  rv32_types::rv32_word    op1,
    input  rv32_types::rv32_word    op2,
    input  rv32_types::int_alu_op_t opsel,
    output rv32_types::rv32_word    result
);
    import rv32_types::*;

    logic [4:0] shamt;

    assign shamt = op2[4:0];

    always_comb begin
        case (opsel)
            ALU_ADD:   result = op1 + op2;
            ALU_SUB:   result = op1 - op2;
            ALU_SLL:   result = op1 << shamt;
            ALU_SLT:   result = {31'b0, $signed(op1) < $signed(op2)};
            ALU_SLTU:  result = {31'b0, op1 < op2};
            ALU_XOR:   result = op1 ^ op2;
            ALU_SRL:   result = op1 >> shamt;
            ALU_SRA:   result = $signed(op1) >>> shamt;
            ALU_OR:    result = op1 | op2;
            ALU_AND:   result = op1 & op2;
            // LUI path, immediate routed to op2
            ALU_PASS2: result = op2;
            default:   result = '0;
        endcase
    end

    // Known operands mean the slot carries a live instruction, so the
    // opcode must be known as well
    always_comb begin
        if (!$isunknown({op1, op2})) begin
            assert (!$isunknown(opsel))
                else $error("int alu opsel unknown with live operands");
        end
    end

endmodule

`default_nettype wire

/* hdl/rv32_branch_unit.sv */
//####################################################################
// Branch decision from rs1/rs2, target is computed by the ALU
//####################################################################
`default_nettype none

module rv32_branch_unit (
    input  rv32_types::rv32_word   op1,
    input  rv32_types::rv32_word   op2,
    input  rv32_types::branch_op_t branch_op,
    output logic                   do_branch
);
    import rv32_types::*;

    logic equal;
    logic less_signed;
    logic less_unsigned;

    assign equal = (op1 == op2);
    assign less_signed = ($signed(op1) < $signed(op2));
    assign less_unsigned = (op1 < op2);

    always_comb begin
        case (branch_op)
            BEQ:       do_branch = equal;
            BNE:       do_branch = !equal;
            BLT:       do_branch = less_signed;
            BGE:       do_branch = !less_signed;
            BLTU:      do_branch = less_unsigned;
            BGEU:      do_branch = !less_unsigned;
            BR_ALWAYS: do_branch = 1'b1;
            default:   do_branch = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/rv32_mul_unit.sv */
//####################################################################
// RV32M multiply, single cycle, full 64-bit product
//####################################################################
`default_nettype none

module rv32_mul_unit (
    input  rv32_types::rv32_word op1,
    input  rv32_types::rv32_word op2,
    input  rv32_types::mul_op_t  opsel,
    output rv32_types::rv32_word result
);
    import rv32_types::*;

    logic op1_signed;
    logic op2_signed;
    logic signed [32:0] op1_ext;
    logic signed [32:0] op2_ext;
    logic signed [65:0] product;

    // MUL low word is the same for any signedness
    assign op1_signed = (opsel == MULH) || (opsel == MULHSU);
    assign op2_signed = (opsel == MULH);

    // One extra bit lets a single signed multiplier cover all variants
    assign op1_ext = $signed({op1_signed & op1[31], op1});
    assign op2_ext = $signed({op2_signed & op2[31], op2});

    assign product = op1_ext * op2_ext;

    always_comb begin
        case (opsel)
            MUL:     result = product[31:0];
            default: result = product[63:32];
        endcase
    end

endmodule

`default_nettype wire

/* hdl/clt_grng_16.sv */
//####################################################################
// Gaussian-like sample from the sum of sixteen LFSR nibbles
// Output range is -120 to 120, consecutive samples are correlated
// Seeding has priority over stepping
//####################################################################
`default_nettype none

module clt_grng_16 (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 enable,
    input  logic                 set_seed,
    input  rv32_types::rv32_word seed,
    output rv32_types::rv32_word sample
);
    import rv32_types::*;

    logic [63:0] state;
    logic [63:0] state_step;
    logic [7:0] nibble_sum;
    logic [9:0] centered;

    // Galois step, feedback from bit 0
    assign state_step = state[0] ? ((state >> 1) ^ GRNG_TAPS) : (state >> 1);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= GRNG_RESET_STATE;
        end else if (set_seed) begin
            // Inverted lower half keeps the state nonzero for any seed
            state <= {seed, ~seed};
        end else if (enable) begin
            state <= state_step;
        end
    end

    always_comb begin
        nibble_sum = '0;
        for (int i = 0; i < 16; i++) begin
            nibble_sum = nibble_sum + {4'b0, state[4*i +: 4]};
        end
        centered = {2'b00, nibble_sum} - GRNG_OFFSET;
    end

    assign sample = {{22{centered[9]}}, centered};

    // All-zero state would lock the LFSR
    a_state_nonzero: assert property (
        @(posedge clk) disable iff (!resetn) state != '0
    ) else $error("GRNG LFSR state reached zero");

endmodule

`default_nettype wire

/* hdl/rv32_exec_stage.sv */
//####################################################################
// RV32IM execute stage, no handshake: stop freezes the output buffer
// Jump decision and target are combinational from the current input
// GRNG state advances regardless of stop
//####################################################################
`default_nettype none

module rv32_exec_stage (
    input  logic                            clk,
    input  logic                            resetn,
    input  rv32_types::decode_exec_buffer_t decode_exec_buff,
    output rv32_types::exec_mem_buffer_t    exec_mem_buff,
    input  logic                            stop,
    output logic                            do_jump,
    output rv32_types::rv32_word            jump_addr,
    input  rv32_types::rv32_word            wb_bypass
);
    import rv32_types::*;

    decoded_instr_t ctrl;
    rv32_word operand [2];
    rv32_word immediate;
    rv32_word alu_in [2];
    rv32_word int_alu_result;
    rv32_word mul_unit_result;
    rv32_word grng_sample;
    exec_mem_buffer_t next_buff;

    assign ctrl = decode_exec_buff.decoded_instr;

    // Operand bypass for rs1 and rs2
    // The third source has no consumer here, its select rides along in ctrl
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            case (ctrl.bypass_rs[i])
                BYPASS_EXEC_BUFF: operand[i] = exec_mem_buff.wb_result;
                BYPASS_MEM_BUFF:  operand[i] = wb_bypass;
                default:          operand[i] = decode_exec_buff.reg_data[i];
            endcase
        end
    end

    rv32_immediate_gen u_immediate_gen (
        .instr_type  (ctrl.t),
        .instruction (decode_exec_buff.instr),
        .immediate   (immediate)
    );

    // ALU input crossbar
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            case (ctrl.int_alu_input[i])
                ALU_IN_REG_1: alu_in[i] = operand[0];
                ALU_IN_REG_2: alu_in[i] = operand[1];
                ALU_IN_PC:    alu_in[i] = decode_exec_buff.pc;
                ALU_IN_IMM:   alu_in[i] = immediate;
                default:      alu_in[i] = '0;
            endcase
        end
    end

    rv32_int_alu u_int_alu (
        .op1    (alu_in[0]),
        .op2    (alu_in[1]),
        .opsel  (ctrl.int_alu_op),
        .result (int_alu_result)
    );

    rv32_branch_unit u_branch_unit (
        .op1       (operand[0]),
        .op2       (operand[1]),
        .branch_op (ctrl.branch_op),
        .do_branch (do_jump)
    );

    // Target from pc+imm, or rs1+imm for JALR
    assign jump_addr = int_alu_result;

    rv32_mul_unit u_mul_unit (
        .op1    (operand[0]),
        .op2    (operand[1]),
        .opsel  (ctrl.mul_op),
        .result (mul_unit_result)
    );

    clt_grng_16 u_grng (
        .clk      (clk),
        .resetn   (resetn),
        .enable   (ctrl.grng_enable),
        .set_seed (ctrl.grng_seed),
        .seed     (operand[0]),
        .sample   (grng_sample)
    );

    // Next buffer contents
    always_comb begin
        next_buff.instr = decode_exec_buff.instr;
        next_buff.pc = decode_exec_buff.pc;
        next_buff.decoded_instr = ctrl;
        next_buff.mem_addr = int_alu_result;
        case (ctrl.wb_result_src)
            WB_PC4:      next_buff.wb_result = decode_exec_buff.pc + RV_PC_STEP;
            WB_INT_ALU:  next_buff.wb_result = int_alu_result;
            // Store data for the memory stage
            WB_STORE:    next_buff.wb_result = operand[1];
            WB_MUL_UNIT: next_buff.wb_result = mul_unit_result;
            WB_GRNG:     next_buff.wb_result = grng_sample;
            default:     next_buff.wb_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            exec_mem_buff.instr <= RV_NOP;
            exec_mem_buff.pc <= '0;
            exec_mem_buff.decoded_instr <= create_nop_ctrl();
        end else if (!stop) begin
            exec_mem_buff <= next_buff;
        end
    end

    // Frozen buffer must also hold for a downstream bypass of it
    a_stop_holds_buffer: assert property (
        @(posedge clk) (resetn && stop) |=> $stable(exec_mem_buff)
    ) else $error("exec_mem_buff changed during stop");

endmodule

`default_nettype wire

/* bench/exec_stage_tb.sv */
//####################################################################
// Table-driven testbench for rv32_exec_stage with a reference model
// Stops at the first mismatch
// GRNG rows never carry stop
//####################################################################
`default_nettype none

module exec_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import rv32_types::*;

    localparam int PERIOD = 8;
    localparam int RESET_CYCLES = 5;
    localparam rv32_word NOP_INSTR = 32'h0000_0013;
    // Right-shift Galois form of taps 64, 63, 61 and 60
    localparam logic [63:0] LFSR_TAPS =
        (64'b1 << 63) | (64'b1 << 62) | (64'b1 << 60) | (64'b1 << 59);

    typedef struct packed {
        decode_exec_buffer_t dec;
        rv32_word bypass;
        logic stall;
        logic exp_jump;
    } row_t;

    logic clk;
    logic resetn;
    logic stop;
    logic do_jump;
    rv32_word jump_addr;
    rv32_word wb_bypass;
    decode_exec_buffer_t decode_exec_buff;
    exec_mem_buffer_t exec_mem_buff;

    row_t rows [$];
    exec_mem_buffer_t exp_buff;
    logic [63:0] lfsr_model;
    rv32_word next_pc;
    integer seed = 32'hfe4d_3505;
    logic table_ready = 1'b0;

    rv32_exec_stage UUT (
        .clk              (clk),
        .resetn           (resetn),
        .decode_exec_buff (decode_exec_buff),
        .exec_mem_buff    (exec_mem_buff),
        .stop             (stop),
        .do_jump          (do_jump),
        .jump_addr        (jump_addr),
        .wb_bypass        (wb_bypass)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input rv32_word exp, input rv32_word got);
        if (got !== exp) begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_ctrl(input decoded_instr_t exp);
        if (exec_mem_buff.decoded_instr !== exp) begin
            $display("Fail at %0t: exec_mem_buff.decoded_instr expected %h, got %h",
                     $time, exp, exec_mem_buff.decoded_instr);
            abort_run();
        end
    endtask

    task automatic check_buffer(input exec_mem_buffer_t exp);
        if (exec_mem_buff !== exp) begin
            $display("Fail at %0t: exec_mem_buff expected %h, got %h",
                     $time, exp, exec_mem_buff);
            abort_run();
        end
    endtask

    task automatic check_jump(input logic exp_do, input rv32_word exp_addr);
        if (do_jump !== exp_do) begin
            $display("Fail at %0t: do_jump expected %b, got %b", $time, exp_do, do_jump);
            abort_run();
        end
        check_word("jump_addr", exp_addr, jump_addr);
    endtask

    task automatic check_sample_range(input rv32_word s);
        if ($signed(s) < -120 || $signed(s) > 120) begin
            $display("Fail at %0t: exec_mem_buff.wb_result sample %0d outside -120 to 120",
                     $time, $signed(s));
            abort_run();
        end
    endtask

    function automatic rv32_word next_random();
        return $random(seed);
    endfunction

    // Empty slot with every select NONE or ZERO, all encoding as zero
    function automatic decoded_instr_t nop_ctrl();
        decoded_instr_t c;
        c = '0;
        c.t = FMT_I;
        return c;
    endfunction

    function automatic decoded_instr_t make_ctrl(instr_type_t t, alu_in_sel_t in0,
            alu_in_sel_t in1, int_alu_op_t op, branch_op_t br, mul_op_t mop, wb_src_t wb);
        decoded_instr_t c;
        c = nop_ctrl();
        c.t = t;
        c.int_alu_input[0] = in0;
        c.int_alu_input[1] = in1;
        c.int_alu_op = op;
        c.branch_op = br;
        c.mul_op = mop;
        c.wb_result_src = wb;
        c.reg_write = 1'b1;
        return c;
    endfunction

    function automatic logic lt_signed(rv32_word a, rv32_word b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic logic taken(branch_op_t op, rv32_word a, rv32_word b);
        case (op)
            BEQ:       return a == b;
            BNE:       return a != b;
            BLT:       return lt_signed(a, b);
            BGE:       return !lt_signed(a, b);
            BLTU:      return a < b;
            BGEU:      return !(a < b);
            BR_ALWAYS: return 1'b1;
            default:   return 1'b0;
        endcase
    endfunction

    // Immediate bits packed at the top and shifted down with sign fill
    function automatic rv32_word imm_model(instr_type_t t, rv32_word ins);
        case (t)
            FMT_I:   return $signed({ins[31:20], 20'b0}) >>> 20;
            FMT_S:   return $signed({ins[31:25], ins[11:7], 20'b0}) >>> 20;
            FMT_B:   return $signed({ins[31], ins[7], ins[30:25], ins[11:8], 20'b0}) >>> 19;
            FMT_U:   return {ins[31:12], 12'b0};
            FMT_J:   return $signed({ins[31], ins[19:12], ins[20], ins[30:21], 12'b0}) >>> 11;
            default: return '0;
        endcase
    endfunction

    function automatic rv32_word pick_input(alu_in_sel_t sel, rv32_word rs1, rv32_word rs2,
            rv32_word pc, rv32_word imm);
        case (sel)
            ALU_IN_REG_1: return rs1;
            ALU_IN_REG_2: return rs2;
            ALU_IN_PC:    return pc;
            ALU_IN_IMM:   return imm;
            default:      return '0;
        endcase
    endfunction

    function automatic rv32_word alu_model(int_alu_op_t op, rv32_word a, rv32_word b);
        logic [63:0] wide;
        wide = {{32{a[31]}}, a} >> b[4:0];
        case (op)
            ALU_ADD:   return a + b;
            ALU_SUB:   return a + ~b + 32'd1;
            ALU_SLL:   return a << b[4:0];
            ALU_SLT:   return {31'b0, lt_signed(a, b)};
            ALU_SLTU:  return {31'b0, a < b};
            ALU_XOR:   return a ^ b;
            ALU_SRL:   return a >> b[4:0];
            ALU_SRA:   return wide[31:0];
            ALU_OR:    return a | b;
            ALU_AND:   return a & b;
            ALU_PASS2: return b;
            default:   return '0;
        endcase
    endfunction

    // Two's complement product modulo 2^64 of the extended operands
    function automatic rv32_word mul_model(mul_op_t op, rv32_word a, rv32_word b);
        logic [63:0] xa;
        logic [63:0] xb;
        logic [63:0] p;
        xa = (op == MULH || op == MULHSU) ? {{32{a[31]}}, a} : {32'b0, a};
        xb = (op == MULH) ? {{32{b[31]}}, b} : {32'b0, b};
        p = xa * xb;
        return (op == MUL) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic [63:0] lfsr_next(logic [63:0] s);
        logic [63:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ LFSR_TAPS;
        end
        return n;
    endfunction

    function automatic rv32_word grng_model(logic [63:0] s);
        int sum;
        sum = 0;
        for (int k = 0; k < 16; k++) begin
            sum = sum + int'(s[4*k +: 4]);
        end
        return rv32_word'(sum - 120);
    endfunction

    task automatic add_row(input rv32_word instr, input rv32_word r1, input rv32_word r2,
            input decoded_instr_t c, input rv32_word byp, input logic stall);
        row_t r;
        r.dec.instr = instr;
        r.dec.pc = next_pc;
        r.dec.reg_data[0] = r1;
        r.dec.reg_data[1] = r2;
        r.dec.reg_data[2] = next_random();
        r.dec.decoded_instr = c;
        r.bypass = byp;
        r.stall = stall;
        // Branch rows never use bypass, so the table operands decide
        r.exp_jump = taken(c.branch_op, r1, r2);
        rows.push_back(r);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic build_table();
        decoded_instr_t c;
        rv32_word pa [3];
        rv32_word pb [3];
        for (int k = 0; k < 11; k++) begin
            c = make_ctrl(FMT_R, ALU_IN_REG_1, ALU_IN_REG_2, int_alu_op_t'(k), BR_NONE, MUL,
                          WB_INT_ALU);
            add_row(next_random(), next_random(), next_random(), c, '0, 1'b0);
        end
        c = make_ctrl(FMT_R, ALU_IN_REG_2, ALU_IN_REG_1, ALU_SUB, BR_NONE, MUL, WB_INT_ALU);
        add_row(next_random(), next_random(), next_random(), c, '0, 1'b0);
        // rs1 plus the immediate of each format and zero for R
        for (int k = 0; k < 6; k++) begin
            c = make_ctrl(instr_type_t'(k), ALU_IN_REG_1, ALU_IN_IMM, ALU_ADD, BR_NONE, MUL,
                          WB_INT_ALU);
            add_row(next_random(), next_random(), next_random(), c, '0, 1'b0);
        end
        // LUI and AUIPC
        c = make_ctrl(FMT_U, ALU_IN_ZERO, ALU_IN_IMM, ALU_PASS2, BR_NONE, MUL, WB_INT_ALU);
        add_row(next_random(), next_random(), next_random(), c, '0, 1'b0);
        c = make_ctrl(FMT_U, ALU_IN_PC, ALU_IN_IMM, ALU_ADD, BR_NONE, MUL, WB_INT_ALU);
        add_row(next_random(), next_random(), next_random(), c, '0, 1'b0);
        // Equal, signed less but unsigned greater, and the reverse
        pa[0] = 32'd7;
        pb[0] = 32'd7;
        pa[1] = 32'hffff_fff0;
        pb[1] = 32'd1;
        pa[2] = 32'd1;
        pb[2] = 32'hffff_fff0;
        for (int b = 1; b < 7; b++) begin
            for (int p = 0; p < 3; p++) begin
                c = make_ctrl(FMT_B, ALU_IN_PC, ALU_IN_IMM, ALU_ADD, branch_op_t'(b), MUL,
                              WB_NONE);
                add_row(next_random(), pa[p], pb[p], c, '0, 1'b0);
            end
        end
        // JAL and JALR
        c = make_ctrl(FMT_J, ALU_IN_PC, ALU_IN_IMM, ALU_ADD, BR_ALWAYS, MUL, WB_PC4);
        add_row(next_random(), next_random(), next_random(), c, '0, 1'b0);
        c = make_ctrl(FMT_I, ALU_IN_REG_1, ALU_IN_IMM, ALU_ADD, BR_ALWAYS, MUL, WB_PC4);
        add_row(next_random(), next_random(), next_random(), c, '0, 1'b0);
        pa[0] = next_random();
        pb[0] = next_random();
        pa[1] = 32'h8000_0000;
        pb[1] = 32'h8000_0000;
        pa[2] = 32'hffff_ffff;
        pb[2] = 32'h7fff_ffff;
        for (int m = 0; m < 4; m++) begin
            for (int p = 0; p < 3; p++) begin
                c = make_ctrl(FMT_R, ALU_IN_REG_1, ALU_IN_REG_2, ALU_ADD, BR_NONE, mul_op_t'(m),
                              WB_MUL_UNIT);
                add_row(next_random(), pa[p], pb[p], c, '0, 1'b0);
            end
        end
        c = make_ctrl(FMT_R, ALU_IN_REG_1, ALU_IN_REG_2, ALU_ADD, BR_NONE, MUL, WB_INT_ALU);
        c.bypass_rs[0] = BYPASS_EXEC_BUFF;
        add_row(next_random(), next_random(), next_random(), c, '0, 1'b0);
        c = make_ctrl(FMT_R, ALU_IN_REG_1, ALU_IN_REG_2, ALU_SUB, BR_NONE, MUL, WB_INT_ALU);
        c.bypass_rs[1] = BYPASS_MEM_BUFF;
        add_row(next_random(), next_random(), next_random(), c, next_random(), 1'b0);
        // Store data taken from write-back
        c = make_ctrl(FMT_S, ALU_IN_REG_1, ALU_IN_IMM, ALU_ADD, BR_NONE, MUL, WB_STORE);
        c.bypass_rs[1] = BYPASS_MEM_BUFF;
        add_row(next_random(), next_random(), next_random(), c, next_random(), 1'b0);
        c = make_ctrl(FMT_R, ALU_IN_REG_1, ALU_IN_REG_2, ALU_ADD, BR_NONE, MULHU, WB_MUL_UNIT);
        c.bypass_rs[0] = BYPASS_EXEC_BUFF;
        c.bypass_rs[1] = BYPASS_EXEC_BUFF;
        add_row(next_random(), next_random(), next_random(), c, '0, 1'b0);
        // Frozen slot followed by a consumer of the held result
        c = make_ctrl(FMT_R, ALU_IN_REG_1, ALU_IN_REG_2, ALU_XOR, BR_NONE, MUL, WB_INT_ALU);
        add_row(next_random(), next_random(), next_random(), c, '0, 1'b1);
        c = make_ctrl(FMT_R, ALU_IN_REG_1, ALU_IN_REG_2, ALU_ADD, BR_NONE, MUL, WB_INT_ALU);
        c.bypass_rs[0] = BYPASS_EXEC_BUFF;
        add_row(next_random(), next_random(), next_random(), c, '0, 1'b0);
        c = make_ctrl(FMT_R, ALU_IN_ZERO, ALU_IN_ZERO, ALU_ADD, BR_NONE, MUL, WB_GRNG);
        c.grng_seed = 1'b1;
        add_row(next_random(), next_random(), next_random(), c, '0, 1'b0);
        c.grng_seed = 1'b0;
        c.grng_enable = 1'b1;
        for (int k = 0; k < 5; k++) begin
            add_row(next_random(), next_random(), next_random(), c, '0, 1'b0);
        end
    endtask

    task automatic apply_row(input row_t r);
        decoded_instr_t c;
        rv32_word opnd [2];
        rv32_word imm;
        rv32_word alu;
        exec_mem_buffer_t model_next;
        c = r.dec.decoded_instr;
        decode_exec_buff = r.dec;
        wb_bypass = r.bypass;
        stop = r.stall;
        for (int k = 0; k < 2; k++) begin
            case (c.bypass_rs[k])
                BYPASS_EXEC_BUFF: opnd[k] = exp_buff.wb_result;
                BYPASS_MEM_BUFF:  opnd[k] = r.bypass;
                default:          opnd[k] = r.dec.reg_data[k];
            endcase
        end
        imm = imm_model(c.t, r.dec.instr);
        alu = alu_model(c.int_alu_op,
                        pick_input(c.int_alu_input[0], opnd[0], opnd[1], r.dec.pc, imm),
                        pick_input(c.int_alu_input[1], opnd[0], opnd[1], r.dec.pc, imm));
        model_next.instr = r.dec.instr;
        model_next.pc = r.dec.pc;
        model_next.decoded_instr = c;
        model_next.mem_addr = alu;
        case (c.wb_result_src)
            WB_PC4:      model_next.wb_result = r.dec.pc + 32'd4;
            WB_INT_ALU:  model_next.wb_result = alu;
            WB_STORE:    model_next.wb_result = opnd[1];
            WB_MUL_UNIT: model_next.wb_result = mul_model(c.mul_op, opnd[0], opnd[1]);
            WB_GRNG:     model_next.wb_result = grng_model(lfsr_model);
            default:     model_next.wb_result = '0;
        endcase
        // Jump outputs settle well before the rising edge
        #(PERIOD / 4);
        check_jump(r.exp_jump, alu);
        if (!r.stall) begin
            exp_buff = model_next;
        end
        if (c.grng_seed) begin
            lfsr_model = {opnd[0], ~opnd[0]};
        end else if (c.grng_enable) begin
            lfsr_model = lfsr_next(lfsr_model);
        end
    endtask

    initial begin
        resetn = 1'b0;
        stop = 1'b0;
        wb_bypass = '0;
        decode_exec_buff = '0;
        decode_exec_buff.instr = NOP_INSTR;
        decode_exec_buff.decoded_instr = nop_ctrl();
        next_pc = 32'h0000_1000;
        build_table();
        table_ready = 1'b1;
        lfsr_model = GRNG_RESET_STATE;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        // wb_result and mem_addr have no reset value
        check_word("exec_mem_buff.instr", NOP_INSTR, exec_mem_buff.instr);
        check_word("exec_mem_buff.pc", '0, exec_mem_buff.pc);
        check_ctrl(nop_ctrl());
        exp_buff = 'x;
        exp_buff.instr = NOP_INSTR;
        exp_buff.pc = '0;
        exp_buff.decoded_instr = nop_ctrl();
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
            @(negedge clk);
            if (rows[i].dec.decoded_instr.wb_result_src == WB_GRNG) begin
                check_sample_range(exec_mem_buff.wb_result);
            end
            check_buffer(exp_buff);
        end
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin
        wait (table_ready);
        #((rows.size() + RESET_CYCLES + 20) * PERIOD);
        $display("Timeout: the table was not finished in time");
        abort_run();
    end

endmodule

`default_nettype wire

/* vlog.f */
hdl/rv32_types.sv
hdl/rv32_immediate_gen.sv
hdl/rv32_int_alu.sv
hdl/rv32_branch_unit.sv
hdl/rv32_mul_unit.sv
hdl/clt_grng_16.sv
hdl/rv32_exec_stage.sv
bench/exec_stage_tb.sv

/* Makefile */
# Verilator build for the RV32IM execute stage testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= exec_stage_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_TEXT := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Status comes from the search for the pass line, not from the simulator
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
